/* cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter
    import mif_pkg::*;
#(
    parameter int BURST_LEN = 16
) (
    input  wire logic       clk_mif,
    input  wire logic       sys_rst,
    // Engine requests
    input  wire logic       rd_req,
    input  wire byte_addr_t rd_addr,
    input  wire logic       wr_req,
    input  wire byte_addr_t wr_addr,
    // Issue strobes back to the engines
    output logic            rd_done,
    output logic            wr_done,
    // Controller command port
    output logic            mcb_cmd_en,
    output mcb_cmd_t        mcb_cmd,
    input  wire logic       mcb_cmd_full
);

    localparam logic [5:0] CMD_BL = 6'(BURST_LEN - 1);

    localparam logic ISSUE_WAIT = 1'b0;
    localparam logic ISSUE_ACT  = 1'b1;

    logic issue_state;

    ////////////////////////////////////////////////////////////////////////////
    // Issue FSM, one command every two cycles
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            issue_state <= ISSUE_WAIT;
            mcb_cmd_en  <= 1'b0;
            rd_done     <= 1'b0;
            wr_done     <= 1'b0;
        end else begin
            case (issue_state)
                ISSUE_WAIT: begin
                    // Requests only sampled with room in the command FIFO
                    if (!mcb_cmd_full) begin
                        if (rd_req) begin
                            mcb_cmd_en  <= 1'b1;
                            rd_done     <= 1'b1;
                            issue_state <= ISSUE_ACT;
                        end else if (wr_req && (wr_addr < rd_addr)) begin
                            // Write trails read so old data is fetched first
                            mcb_cmd_en  <= 1'b1;
                            wr_done     <= 1'b1;
                            issue_state <= ISSUE_ACT;
                        end
                    end
                end
                ISSUE_ACT: begin
                    // Rest cycle
                    mcb_cmd_en  <= 1'b0;
                    rd_done     <= 1'b0;
                    wr_done     <= 1'b0;
                    issue_state <= ISSUE_WAIT;
                end
                default: begin
                    issue_state <= ISSUE_WAIT;
                end
            endcase
        end
    end

    // Command payload, valid while mcb_cmd_en is high
    always_ff @(posedge clk_mif) begin
        if ((issue_state == ISSUE_WAIT) && !mcb_cmd_full) begin
            if (rd_req) begin
                mcb_cmd <= '{instr: MCB_READ, bl: CMD_BL, byte_addr: rd_addr};
            end else if (wr_req) begin
                mcb_cmd <= '{instr: MCB_WRITE, bl: CMD_BL, byte_addr: wr_addr};
            end
        end
    end

endmodule

`default_nettype wire

/* memif_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// Command port spacing properties
module memif_chk (
    input wire logic clk_mif,
    input wire logic sys_rst,
    input wire logic mcb_cmd_en,
    input wire logic mcb_cmd_full,
    input wire logic rd_done,
    input wire logic wr_done
);

    // Count of failed assertions
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Command spacing
    ////////////////////////////////////////////////////////////////////////////

    // Rest cycle after every command
    a_cmd_gap: assert property (@(posedge clk_mif) disable iff (sys_rst)
        mcb_cmd_en |=> !mcb_cmd_en)
    else begin
        fail_count++;
        $error("mcb_cmd_en high in two consecutive cycles");
    end

    // Full command FIFO blocks the next issue
    a_cmd_full: assert property (@(posedge clk_mif) disable iff (sys_rst)
        (!mcb_cmd_en && mcb_cmd_full) |=> !mcb_cmd_en)
    else begin
        fail_count++;
        $error("mcb_cmd_en rose after mcb_cmd_full was high");
    end

    // Done strobes ride on the command strobe
    a_done_with_cmd: assert property (@(posedge clk_mif) disable iff (sys_rst)
        (rd_done || wr_done) |-> mcb_cmd_en)
    else begin
        fail_count++;
        $error("done strobe without mcb_cmd_en");
    end

    // Exactly one engine owns each command
    a_cmd_one_done: assert property (@(posedge clk_mif) disable iff (sys_rst)
        mcb_cmd_en |-> (rd_done != wr_done))
    else begin
        fail_count++;
        $error("mcb_cmd_en without exactly one done strobe");
    end

endmodule

// Arbiter strobes as seen at the top level
bind memif_top memif_chk chk0 (
    .clk_mif        (clk_mif),
    .sys_rst        (sys_rst),
    .mcb_cmd_en     (mcb_cmd_en),
    .mcb_cmd_full   (mcb_cmd_full),
    .rd_done        (rd_done),
    .wr_done        (wr_done)
);

`default_nettype wire

/* memif_mon.sv */
`timescale 1ns/1ps
`default_nettype none

module memif_mon
    import mif_pkg::*;
#(
    parameter int BURST_LEN   = 16,
    parameter int FRAME_BYTES = 2048
) (
    input  wire logic        clk_mif,
    input  wire logic        sys_rst,
    input  wire logic        vsync,
    // Pixel side
    input  wire pix_word_t   pix_write,
    input  wire logic        pix_write_valid,
    input  wire logic        pix_write_ready,
    input  wire pix_word_t   pix_read,
    input  wire logic        pix_read_valid,
    input  wire logic        pix_read_ready,
    // Controller side
    input  wire logic        mcb_cmd_en,
    input  wire mcb_cmd_t    mcb_cmd,
    input  wire logic        mcb_wr_en,
    input  wire pix_word_t   mcb_wr_data,
    input  wire logic        mcb_wr_full,
    input  wire logic        mcb_rd_en,
    input  wire logic        mcb_rd_empty,
    // Memory readback after the frame
    input  wire logic        mem_chk_valid,
    input  wire logic [31:0] mem_chk_index,
    input  wire pix_word_t   mem_chk_word,
    output int               error_count,
    output int               check_count,
    output logic             stream_done
);

    localparam int BYTES_PER_CMD = WORD_BYTES * BURST_LEN;
    localparam int FRAME_WORDS   = FRAME_BYTES / WORD_BYTES;
    localparam int FRAME_CMDS    = FRAME_WORDS / BURST_LEN;

    // Accepted pixel words in order
    pix_word_t acc_words [0:FRAME_WORDS-1];
    int        acc_count;
    int        rd_words;
    int        rd_cmds;
    int        wr_cmds;
    int        last_rd_addr;
    int        errs;
    int        checks;
    logic      frame_started;
    logic      prev_accept;
    pix_word_t prev_word;

    // Initial video RAM contents at a word index
    function automatic pix_word_t ref_word(input int index);
        pix_word_t   word;
        logic [31:0] mix;
        int          lane;
        for (lane = 0; lane < 8; lane++) begin
            mix        = index * 32'h9E3779B1 + lane * 32'h85EBCA6B + 32'h5A5A0F0F;
            word[lane] = mix[31:16] ^ mix[15:0];
        end
        return word;
    endfunction

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("Fail %s got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        if (cond !== 1'b1) begin
            errs++;
            $display("Error: %s", msg);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command port
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_command();
        int addr;
        addr = int'(mcb_cmd.byte_addr);
        expect_equal("mcb_cmd.bl", mcb_cmd.bl, BURST_LEN - 1);
        if (mcb_cmd.instr == MCB_READ) begin
            expect_equal("mcb_cmd.byte_addr", mcb_cmd.byte_addr, rd_cmds * BYTES_PER_CMD);
            last_rd_addr = addr;
            rd_cmds++;
        end else if (mcb_cmd.instr == MCB_WRITE) begin
            expect_equal("mcb_cmd.byte_addr", mcb_cmd.byte_addr, wr_cmds * BYTES_PER_CMD);
            // Block must be fetched before it is overwritten
            expect_true(addr <= last_rd_addr,
                $sformatf("write to address %0h issued before its read", addr));
            wr_cmds++;
        end else begin
            expect_true(1'b0, "mcb_cmd carries an unknown instruction code");
        end
    endtask

    task automatic check_memory_word();
        if (mem_chk_index < acc_count) begin
            expect_equal($sformatf("mem[%0d]", mem_chk_index), mem_chk_word,
                acc_words[mem_chk_index]);
        end else begin
            expect_true(1'b0, $sformatf("word %0d was never accepted", mem_chk_index));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparison process
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_mif) begin : compare
        if (sys_rst) begin
            acc_count     = 0;
            rd_words      = 0;
            rd_cmds       = 0;
            wr_cmds       = 0;
            last_rd_addr  = -1;
            errs          = 0;
            checks        = 0;
            frame_started = 1'b0;
            prev_accept   = 1'b0;
            prev_word     = '0;
        end else begin
            // Nothing moves before the first frame start
            if (!frame_started) begin
                expect_equal("mcb_cmd_en", mcb_cmd_en, 1'b0);
                expect_equal("mcb_wr_en", mcb_wr_en, 1'b0);
                expect_equal("pix_read_valid", pix_read_valid, 1'b0);
                expect_equal("pix_write_ready", pix_write_ready, 1'b0);
            end
            if (vsync) begin
                frame_started = 1'b1;
            end

            // Stalls gate the handshakes in the same cycle
            expect_true(!(pix_write_ready && mcb_wr_full),
                "pix_write_ready high while mcb_wr_full is high");
            expect_true(!(pix_read_valid && (!pix_read_ready || mcb_rd_empty)),
                "pix_read_valid high without ready and read data");
            // Pop whenever the consumer is ready and the read port holds data
            expect_equal("mcb_rd_en", mcb_rd_en, pix_read_ready && !mcb_rd_empty);

            // Write data port repeats the accepted word one cycle later
            expect_equal("mcb_wr_en", mcb_wr_en, prev_accept);
            if (prev_accept) begin
                expect_equal("mcb_wr_data", mcb_wr_data, prev_word);
            end
            prev_accept = pix_write_valid && pix_write_ready;
            prev_word   = pix_write;
            if (prev_accept) begin
                if (acc_count < FRAME_WORDS) begin
                    acc_words[acc_count] = pix_write;
                end else begin
                    expect_true(1'b0, "more pixel words accepted than one frame holds");
                end
                acc_count++;
            end

            // Linear read stream of the old frame
            if (pix_read_valid) begin
                if (rd_words < FRAME_WORDS) begin
                    expect_equal($sformatf("pix_read[%0d]", rd_words), pix_read,
                        ref_word(rd_words));
                end else begin
                    expect_true(1'b0, "pix_read delivered a word past the frame end");
                end
                rd_words++;
            end

            if (mcb_cmd_en) begin
                check_command();
            end
            if (mem_chk_valid) begin
                check_memory_word();
            end
        end
        error_count <= errs;
        check_count <= checks;
        stream_done <= (rd_words == FRAME_WORDS) && (wr_cmds == FRAME_CMDS);
    end

endmodule

`default_nettype wire

/* memif_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memif_tb
    import mif_pkg::*;
();

    localparam int BURST_LEN   = 16;
    localparam int FRAME_BYTES = 2048;
    localparam int FRAME_WORDS = FRAME_BYTES / WORD_BYTES;
    localparam int CLK_HALF    = 20;
    localparam int RST_CYCLES  = 5;
    // Sixteen cycles of stall budget per frame word
    localparam int WATCHDOG_CYCLES = FRAME_WORDS * 2 * 8;

    logic        clk_mif = 1'b0;
    logic        sys_rst;
    logic        vsync;
    pix_word_t   pix_write;
    logic        pix_write_valid;
    logic        pix_write_ready;
    pix_word_t   pix_read;
    logic        pix_read_valid;
    logic        pix_read_ready;
    logic        mcb_cmd_en;
    mcb_cmd_t    mcb_cmd;
    logic        mcb_cmd_full;
    logic        mcb_wr_en;
    pix_word_t   mcb_wr_data;
    logic        mcb_wr_full;
    logic        mcb_rd_en;
    pix_word_t   mcb_rd_data;
    logic        mcb_rd_empty;
    logic        mem_chk_valid;
    logic [31:0] mem_chk_index;
    pix_word_t   mem_chk_word;
    int          error_count;
    int          check_count;
    logic        stream_done;
    int          seed;
    int          words_sent;
    int          model_errors;
    int          i;

    // Controller model storage
    pix_word_t mem [0:FRAME_WORDS-1];
    pix_word_t wr_queue [$];
    pix_word_t rd_queue [$];

    always #(CLK_HALF) clk_mif = ~clk_mif;

    memif_top #(
        .BURST_LEN      (BURST_LEN),
        .FRAME_BYTES    (FRAME_BYTES)
    ) dut0 (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .vsync          (vsync),
        .pix_write      (pix_write),
        .pix_write_valid(pix_write_valid),
        .pix_write_ready(pix_write_ready),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .mcb_cmd_en     (mcb_cmd_en),
        .mcb_cmd        (mcb_cmd),
        .mcb_cmd_full   (mcb_cmd_full),
        .mcb_wr_en      (mcb_wr_en),
        .mcb_wr_data    (mcb_wr_data),
        .mcb_wr_full    (mcb_wr_full),
        .mcb_rd_en      (mcb_rd_en),
        .mcb_rd_data    (mcb_rd_data),
        .mcb_rd_empty   (mcb_rd_empty)
    );

    memif_mon #(
        .BURST_LEN      (BURST_LEN),
        .FRAME_BYTES    (FRAME_BYTES)
    ) mon0 (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .vsync          (vsync),
        .pix_write      (pix_write),
        .pix_write_valid(pix_write_valid),
        .pix_write_ready(pix_write_ready),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .mcb_cmd_en     (mcb_cmd_en),
        .mcb_cmd        (mcb_cmd),
        .mcb_wr_en      (mcb_wr_en),
        .mcb_wr_data    (mcb_wr_data),
        .mcb_wr_full    (mcb_wr_full),
        .mcb_rd_en      (mcb_rd_en),
        .mcb_rd_empty   (mcb_rd_empty),
        .mem_chk_valid  (mem_chk_valid),
        .mem_chk_index  (mem_chk_index),
        .mem_chk_word   (mem_chk_word),
        .error_count    (error_count),
        .check_count    (check_count),
        .stream_done    (stream_done)
    );

    function automatic pix_word_t random_word();
        pix_word_t word;
        int        part;
        for (part = 0; part < 4; part++) begin
            word[part*2 +: 2] = $random(seed);
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Random stimulus
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_mif) begin : stimulus
        if (sys_rst) begin
            pix_write_valid <= 1'b0;
            pix_read_ready  <= 1'b0;
            mcb_cmd_full    <= 1'b0;
            mcb_wr_full     <= 1'b0;
        end else begin
            // Next pixel word once the current one is taken
            if (pix_write_valid && pix_write_ready) begin
                words_sent = words_sent + 1;
                pix_write <= random_word();
            end
            pix_write_valid <= (words_sent < FRAME_WORDS) && (($random(seed) & 3) != 0);
            pix_read_ready  <= ($random(seed) & 3) != 0;
            // Controller stalls about one cycle in five
            mcb_cmd_full    <= ($unsigned($random(seed)) % 5) == 0;
            mcb_wr_full     <= ($unsigned($random(seed)) % 5) == 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Controller model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_mif) begin : ctrl_model
        int base;
        int k;
        if (sys_rst) begin
            wr_queue.delete();
            rd_queue.delete();
            mcb_rd_empty <= 1'b1;
        end else begin
            if (mcb_rd_en && (rd_queue.size() > 0)) begin
                void'(rd_queue.pop_front());
            end
            if (mcb_wr_en) begin
                wr_queue.push_back(mcb_wr_data);
            end
            if (mcb_cmd_en) begin
                base = int'(mcb_cmd.byte_addr) / WORD_BYTES;
                for (k = 0; k < BURST_LEN; k++) begin
                    if ((base + k) >= FRAME_WORDS) begin
                        model_errors++;
                        $display("Error: command address %0h runs past video RAM",
                            mcb_cmd.byte_addr);
                        break;
                    end else if (mcb_cmd.instr == MCB_WRITE) begin
                        if (wr_queue.size() == 0) begin
                            model_errors++;
                            $display("Error: write command at %0h found too few data words",
                                mcb_cmd.byte_addr);
                            break;
                        end
                        mem[base + k] = wr_queue.pop_front();
                    end else begin
                        // Read data is a snapshot taken at command time
                        rd_queue.push_back(mem[base + k]);
                    end
                end
            end
            // First word falls through
            mcb_rd_empty <= (rd_queue.size() == 0);
            if (rd_queue.size() > 0) begin
                mcb_rd_data <= rd_queue[0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        int total;
        seed            = 26435;
        sys_rst         = 1'b1;
        vsync           = 1'b0;
        pix_write_valid = 1'b0;
        pix_read_ready  = 1'b0;
        mcb_cmd_full    = 1'b0;
        mcb_wr_full     = 1'b0;
        mcb_rd_data     = '0;
        mcb_rd_empty    = 1'b1;
        mem_chk_valid   = 1'b0;
        mem_chk_index   = '0;
        mem_chk_word    = '0;
        words_sent      = 0;
        model_errors    = 0;
        pix_write       = random_word();
        for (i = 0; i < FRAME_WORDS; i++) begin
            mem[i] = mon0.ref_word(i);
        end

        repeat (RST_CYCLES) @(posedge clk_mif);
        sys_rst <= 1'b0;
        // Idle window with pixel input already offered
        repeat (8) @(posedge clk_mif);
        vsync <= 1'b1;
        @(posedge clk_mif);
        vsync <= 1'b0;

        while (!stream_done) @(posedge clk_mif);
        repeat (4) @(posedge clk_mif);

        // Stream the model memory back to the monitor
        for (i = 0; i < FRAME_WORDS; i++) begin
            mem_chk_valid <= 1'b1;
            mem_chk_index <= i;
            mem_chk_word  <= mem[i];
            @(posedge clk_mif);
        end
        mem_chk_valid <= 1'b0;
        repeat (2) @(posedge clk_mif);

        total = error_count + model_errors + dut0.chk0.fail_count;
        $display("Checks: %0d, monitor errors: %0d, model errors: %0d, assertion errors: %0d",
            check_count, error_count, model_errors, dut0.chk0.fail_count);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RST_CYCLES + WATCHDOG_CYCLES) @(posedge clk_mif);
        $display("Timeout: frame did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, monitor errors: %0d, model errors: %0d",
            check_count, error_count, model_errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* memif_top.f */
mif_pkg.sv
wr_burst_ctrl.sv
rd_burst_ctrl.sv
cmd_arbiter.sv
memif_top.sv
memif_chk.sv
memif_mon.sv
memif_tb.sv

/* memif_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memif_top
    import mif_pkg::*;
#(
    parameter int BURST_LEN   = 16,
    parameter int FRAME_BYTES = 3840000
) (
    input  wire logic      clk_mif,
    input  wire logic      sys_rst,
    input  wire logic      vsync,
    // Pixel input
    input  wire pix_word_t pix_write,
    input  wire logic      pix_write_valid,
    output logic           pix_write_ready,
    // Pixel output
    output pix_word_t      pix_read,
    output logic           pix_read_valid,
    input  wire logic      pix_read_ready,
    // Controller command port
    output logic           mcb_cmd_en,
    output mcb_cmd_t       mcb_cmd,
    input  wire logic      mcb_cmd_full,
    // Controller write data port
    output logic           mcb_wr_en,
    output pix_word_t      mcb_wr_data,
    input  wire logic      mcb_wr_full,
    // Controller read data port
    output logic           mcb_rd_en,
    input  wire pix_word_t mcb_rd_data,
    input  wire logic      mcb_rd_empty
);

    logic       wr_req;
    logic       wr_done;
    byte_addr_t wr_addr;
    logic       rd_req;
    logic       rd_done;
    byte_addr_t rd_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Burst engines
    ////////////////////////////////////////////////////////////////////////////

    wr_burst_ctrl #(
        .BURST_LEN      (BURST_LEN),
        .FRAME_BYTES    (FRAME_BYTES)
    ) wr_ctrl0 (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .vsync          (vsync),
        .pix_write      (pix_write),
        .pix_write_valid(pix_write_valid),
        .pix_write_ready(pix_write_ready),
        .mcb_wr_en      (mcb_wr_en),
        .mcb_wr_data    (mcb_wr_data),
        .mcb_wr_full    (mcb_wr_full),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_done        (wr_done)
    );

    rd_burst_ctrl #(
        .BURST_LEN      (BURST_LEN),
        .FRAME_BYTES    (FRAME_BYTES)
    ) rd_ctrl0 (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .vsync          (vsync),
        .pix_read       (pix_read),
        .pix_read_valid (pix_read_valid),
        .pix_read_ready (pix_read_ready),
        .mcb_rd_en      (mcb_rd_en),
        .mcb_rd_data    (mcb_rd_data),
        .mcb_rd_empty   (mcb_rd_empty),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done)
    );

    // Shared command port, reads first
    cmd_arbiter #(
        .BURST_LEN      (BURST_LEN)
    ) arb0 (
        .clk_mif        (clk_mif),
        .sys_rst        (sys_rst),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .rd_done        (rd_done),
        .wr_done        (wr_done),
        .mcb_cmd_en     (mcb_cmd_en),
        .mcb_cmd        (mcb_cmd),
        .mcb_cmd_full   (mcb_cmd_full)
    );

endmodule

`default_nettype wire

/* mif_pkg.sv */
`default_nettype none

package mif_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // User port geometry
    ////////////////////////////////////////////////////////////////////////////

    // 128 bit user port
    localparam int WORD_BYTES = 16;

    // Byte address width of the controller command port
    localparam int ADDR_W = 30;

    ////////////////////////////////////////////////////////////////////////////
    // Data and address types
    ////////////////////////////////////////////////////////////////////////////

    // One user port word holds eight 16 bit pixels
    typedef logic [7:0][15:0] pix_word_t;

    // Byte address into video RAM
    typedef logic [ADDR_W-1:0] byte_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Command port
    ////////////////////////////////////////////////////////////////////////////

    // Controller instruction codes
    typedef enum logic [2:0] {
        MCB_WRITE = 3'b000,
        MCB_READ  = 3'b001
    } mcb_instr_e;

    // Burst length field carries words minus one
    typedef struct packed {
        mcb_instr_e instr;
        logic [5:0] bl;
        byte_addr_t byte_addr;
    } mcb_cmd_t;

endpackage

`default_nettype wire

/* rd_burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_burst_ctrl
    import mif_pkg::*;
#(
    parameter int BURST_LEN   = 16,
    parameter int FRAME_BYTES = 3840000
) (
    input  wire logic      clk_mif,
    input  wire logic      sys_rst,
    input  wire logic      vsync,
    // Pixel output
    output pix_word_t      pix_read,
    output logic           pix_read_valid,
    input  wire logic      pix_read_ready,
    // Controller read data port, first word fall through
    output logic           mcb_rd_en,
    input  wire pix_word_t mcb_rd_data,
    input  wire logic      mcb_rd_empty,
    // Arbiter handshake
    output logic           rd_req,
    output byte_addr_t     rd_addr,
    input  wire logic      rd_done
);

    localparam int BYTES_PER_CMD = WORD_BYTES * BURST_LEN;

    localparam byte_addr_t ADDR_STEP = byte_addr_t'(BYTES_PER_CMD);
    localparam byte_addr_t LAST_ADDR = byte_addr_t'(FRAME_BYTES - BYTES_PER_CMD);

    localparam logic [1:0] RD_IDLE  = 2'd0;
    localparam logic [1:0] RD_WDATA = 2'd1;
    localparam logic [1:0] RD_DRAIN = 2'd2;
    localparam logic [1:0] RD_ISSUE = 2'd3;

    logic [1:0] rd_state;

    // Pop whenever the consumer takes a word
    assign pix_read_valid = pix_read_ready && !mcb_rd_empty;
    assign mcb_rd_en      = pix_read_valid;
    assign pix_read       = mcb_rd_data;
    assign rd_req         = (rd_state == RD_ISSUE);

    ////////////////////////////////////////////////////////////////////////////
    // Burst FSM, at most one burst held in the read port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            rd_state <= RD_IDLE;
            rd_addr  <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (vsync) begin
                        rd_addr  <= '0;
                        rd_state <= RD_DRAIN;
                    end
                end
                RD_WDATA: begin
                    // First word of the burst arrived
                    if (!mcb_rd_empty) begin
                        rd_state <= RD_DRAIN;
                    end
                end
                RD_DRAIN: begin
                    // Port empty and consumer ready for more
                    if (pix_read_ready && mcb_rd_empty) begin
                        rd_state <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    if (rd_done) begin
                        // address steps past the frame end on the last burst
                        rd_addr <= rd_addr + ADDR_STEP;
                        if (rd_addr == LAST_ADDR) begin
                            rd_state <= RD_IDLE;
                        end else begin
                            rd_state <= RD_WDATA;
                        end
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* wr_burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_burst_ctrl
    import mif_pkg::*;
#(
    parameter int BURST_LEN   = 16,
    parameter int FRAME_BYTES = 3840000
) (
    input  wire logic      clk_mif,
    input  wire logic      sys_rst,
    input  wire logic      vsync,
    // Pixel input
    input  wire pix_word_t pix_write,
    input  wire logic      pix_write_valid,
    output logic           pix_write_ready,
    // Controller write data port
    output logic           mcb_wr_en,
    output pix_word_t      mcb_wr_data,
    input  wire logic      mcb_wr_full,
    // Arbiter handshake
    output logic           wr_req,
    output byte_addr_t     wr_addr,
    input  wire logic      wr_done
);

    localparam int BYTES_PER_CMD = WORD_BYTES * BURST_LEN;
    localparam int FRAME_WORDS   = FRAME_BYTES / WORD_BYTES;
    // Buffered word count never exceeds one frame
    localparam int CNT_W         = $clog2(FRAME_WORDS + 1);

    localparam byte_addr_t ADDR_STEP = byte_addr_t'(BYTES_PER_CMD);
    localparam byte_addr_t LAST_ADDR = byte_addr_t'(FRAME_BYTES - BYTES_PER_CMD);

    localparam logic [1:0] WR_IDLE  = 2'd0;
    localparam logic [1:0] WR_PUSH  = 2'd1;
    localparam logic [1:0] WR_ISSUE = 2'd2;

    logic [1:0]       wr_state;
    logic [CNT_W-1:0] wr_count;
    logic             pix_accept;

    // Words only flow while a frame is active
    assign pix_accept      = pix_write_valid && !mcb_wr_full && (wr_state != WR_IDLE);
    assign pix_write_ready = pix_accept;
    assign wr_req          = (wr_state == WR_ISSUE);

    ////////////////////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            wr_state <= WR_IDLE;
            wr_count <= '0;
            wr_addr  <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    // Frame start rewinds to the top of the buffer
                    if (vsync) begin
                        wr_addr  <= '0;
                        wr_count <= '0;
                        wr_state <= WR_PUSH;
                    end
                end
                WR_PUSH: begin
                    // One burst worth is buffered in the controller
                    if (wr_count >= CNT_W'(BURST_LEN)) begin
                        wr_count <= wr_count + CNT_W'(pix_accept) - CNT_W'(BURST_LEN);
                        wr_state <= WR_ISSUE;
                    end else begin
                        wr_count <= wr_count + CNT_W'(pix_accept);
                    end
                end
                WR_ISSUE: begin
                    // Input keeps streaming while the command waits
                    wr_count <= wr_count + CNT_W'(pix_accept);
                    if (wr_done) begin
                        wr_addr <= wr_addr + ADDR_STEP;
                        if (wr_addr == LAST_ADDR) begin
                            wr_state <= WR_IDLE;
                        end else begin
                            wr_state <= WR_PUSH;
                        end
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // Write data port lags the accept by one cycle
    always_ff @(posedge clk_mif) begin
        if (sys_rst) begin
            mcb_wr_en <= 1'b0;
        end else begin
            mcb_wr_en <= pix_accept;
        end
    end

    always_ff @(posedge clk_mif) begin
        mcb_wr_data <= pix_write;
    end

endmodule

`default_nettype wire
